// ==== verilog/eth_frame_pkg.sv ====
package eth_frame_pkg;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;      // Repeated before the SFD
    localparam logic [7:0] SFD_BYTE = 8'hD5;           // Start of frame delimiter
    localparam int PREAMBLE_LEN = 7;                   // Preamble bytes ahead of the SFD
    localparam int FCS_LEN = 4;                        // CRC-32 trailer bytes
    localparam int IFG_LEN = 12;                       // Minimum idle cycles between frames
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;  // CRC register seed
    localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B; // Good-frame residue, normal bit order
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;  // Reflected IEEE 802.3 polynomial

    // One byte through the reflected CRC-32, LSB of the byte first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h00_0000, data};                 // Fold the byte into the low bits
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1); // Shift out one bit
        end
        return c;
    endfunction

endpackage

// ==== verilog/eth_stream_pkg.sv ====
package eth_stream_pkg;

    typedef logic [7:0] byte_t;                        // One octet on the wire or the stream

    // One beat of the internal byte stream
    typedef struct packed {
        byte_t data;                                   // Payload byte
        logic  last;                                   // Final byte of the frame
        logic  err;                                    // Bad frame, only meaningful with last
    } eth_beat_t;

endpackage

// ==== verilog/eth_stream_if.sv ====
interface eth_stream_if import eth_stream_pkg::*; ();

    eth_beat_t beat;                                   // Data, last and err
    logic      valid;                                  // Source has a beat
    logic      ready;                                  // Sink takes the beat this cycle

    modport source (
        output beat,
        output valid,
        input  ready
    );

    modport sink (
        input  beat,
        input  valid,
        output ready
    );

endinterface

// ==== verilog/pkt_fifo.sv ====
module pkt_fifo import eth_stream_pkg::*; #(
    parameter int FIFO_DEPTH = 2048,                   // Beats of storage
    parameter int FRAME_CNT_W = 9                      // Width of the stored-frame counter
) (
    input  logic          clk_125,
    input  logic          i_reset_n,
    eth_stream_if.sink    wr,                          // Write side
    eth_stream_if.source  rd                           // Read side, whole frames only
);

    localparam int AW = $clog2(FIFO_DEPTH);            // Pointer width
    localparam int CW = $clog2(FIFO_DEPTH + 1);        // Occupancy width, holds FIFO_DEPTH

    eth_beat_t              mem [FIFO_DEPTH];          // Beat storage
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [CW-1:0]          count;                     // Beats currently stored
    logic [FRAME_CNT_W-1:0] frame_cnt;                 // Complete frames currently stored
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_eof;
    logic                   rd_eof;

    assign wr.ready = (count != CW'(FIFO_DEPTH));      // Space left
    assign rd.valid = (frame_cnt != '0) && (count != '0); // Hold off until a full frame is in
    assign rd.beat  = mem[rd_ptr];                     // Head of the queue

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;
    assign wr_eof  = wr_fire && wr.beat.last;          // Frame finished on the write side
    assign rd_eof  = rd_fire && rd.beat.last;          // Frame drained on the read side

    always_ff @(posedge clk_125) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr.beat;
        end
    end

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at depth
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;               // Idle or write and read together
            endcase

            if (wr_eof && !rd_eof) begin
                frame_cnt <= frame_cnt + 1'b1;         // Visible to the reader next cycle
            end else if (rd_eof && !wr_eof) begin
                frame_cnt <= frame_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/eth_tx_mac.sv ====
module eth_tx_mac import eth_frame_pkg::*, eth_stream_pkg::*; (
    input  logic          clk_125,
    input  logic          i_reset_n,
    eth_stream_if.sink    s,                           // Whole frames from the TX FIFO
    output byte_t         gmii_txd,
    output logic          gmii_tx_en
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PRE,
        TX_SFD,
        TX_DATA,
        TX_FCS,
        TX_GAP
    } tx_state_t;

    tx_state_t   state_q;
    tx_state_t   state_d;
    logic [3:0]  cnt_q;                                // Preamble, FCS and gap counter
    logic [3:0]  cnt_d;
    logic [31:0] crc_q;                                // Running CRC, then the FCS shifter
    logic [31:0] crc_d;
    byte_t       txd_d;
    logic        en_d;

    // Payload is pulled one byte per cycle, the FIFO never runs dry inside a frame
    assign s.ready = (state_q == TX_DATA);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        crc_d   = crc_q;
        txd_d   = 8'h00;                               // Idle line
        en_d    = 1'b0;
        case (state_q)
            TX_IDLE: begin
                if (s.valid) begin                     // A complete frame waits
                    txd_d   = PREAMBLE_BYTE;           // First preamble byte goes out now
                    en_d    = 1'b1;
                    cnt_d   = 4'd1;
                    state_d = TX_PRE;
                end
            end
            TX_PRE: begin
                txd_d = PREAMBLE_BYTE;
                en_d  = 1'b1;
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == 4'(PREAMBLE_LEN - 1)) begin
                    state_d = TX_SFD;                  // Seventh byte loaded
                end
            end
            TX_SFD: begin
                txd_d   = SFD_BYTE;
                en_d    = 1'b1;
                crc_d   = CRC_INIT;                    // Seed for the payload
                state_d = TX_DATA;
            end
            TX_DATA: begin
                txd_d = s.beat.data;
                en_d  = 1'b1;
                crc_d = crc32_byte(crc_q, s.beat.data);
                if (s.beat.last) begin
                    cnt_d   = '0;
                    state_d = TX_FCS;
                end
            end
            TX_FCS: begin
                txd_d = ~crc_q[7:0];                   // Complemented, low byte first
                en_d  = 1'b1;
                crc_d = {8'h00, crc_q[31:8]};
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == 4'(FCS_LEN - 1)) begin
                    cnt_d   = '0;
                    state_d = TX_GAP;
                end
            end
            TX_GAP: begin
                cnt_d = cnt_q + 1'b1;                  // Line stays idle
                if (cnt_q == 4'(IFG_LEN - 1)) begin
                    state_d = TX_IDLE;
                end
            end
            default: state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state_q    <= TX_IDLE;
            cnt_q      <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            state_q    <= state_d;
            cnt_q      <= cnt_d;
            gmii_tx_en <= en_d;
        end
    end

    always_ff @(posedge clk_125) begin
        crc_q    <= crc_d;
        gmii_txd <= txd_d;                             // Registered GMII data
    end

endmodule

// ==== verilog/eth_rx_mac.sv ====
module eth_rx_mac import eth_frame_pkg::*, eth_stream_pkg::*; (
    input  logic          clk_125,
    input  logic          i_reset_n,
    input  byte_t         gmii_rxd,
    input  logic          gmii_rx_dv,
    eth_stream_if.source  m                            // Payload beats to the RX FIFO
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PRE,
        RX_DATA,
        RX_SKIP
    } rx_state_t;

    rx_state_t   state_q;
    byte_t       dly_q [4];                            // Holds back the last four bytes, the FCS
    byte_t       pend_q;                               // Byte leaving the delay line
    logic [2:0]  fill_q;                               // Bytes seen since the SFD, saturates at 5
    logic [31:0] crc_q;                                // CRC over payload and FCS
    logic [31:0] crc_rev;
    logic        ovf_q;                                // A beat met a full FIFO
    logic        eof;
    logic        crc_bad;

    assign crc_rev = {<<{crc_q}};                      // Residue constant is in normal order
    assign crc_bad = (crc_rev != CRC_RESIDUE);
    assign eof     = !gmii_rx_dv;                      // dv low ends the frame

    // pend_q is payload once a fifth byte arrived, the last one goes out as dv drops
    assign m.valid = (state_q == RX_DATA) && (fill_q == 3'd5);
    assign m.beat  = '{data: pend_q, last: eof, err: eof && (crc_bad || ovf_q)};

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state_q <= RX_IDLE;
            fill_q  <= '0;
            ovf_q   <= 1'b0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    if (gmii_rx_dv) begin
                        state_q <= (gmii_rxd == PREAMBLE_BYTE) ? RX_PRE : RX_SKIP;
                    end
                end
                RX_PRE: begin
                    if (!gmii_rx_dv) begin
                        state_q <= RX_IDLE;            // Preamble only, nothing to do
                    end else if (gmii_rxd == SFD_BYTE) begin
                        state_q <= RX_DATA;
                        fill_q  <= '0;
                        ovf_q   <= 1'b0;
                    end else if (gmii_rxd != PREAMBLE_BYTE) begin
                        state_q <= RX_SKIP;            // Garbled preamble
                    end
                end
                RX_DATA: begin
                    if (gmii_rx_dv) begin
                        if (fill_q != 3'd5) begin
                            fill_q <= fill_q + 1'b1;
                        end
                        if (m.valid && !m.ready) begin
                            ovf_q <= 1'b1;             // Byte lost, flag on the last beat
                        end
                    end else begin
                        state_q <= RX_IDLE;            // Last beat issued this cycle
                    end
                end
                RX_SKIP: begin
                    if (!gmii_rx_dv) begin
                        state_q <= RX_IDLE;            // Wait out the bad frame
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125) begin
        if (state_q == RX_PRE) begin
            crc_q <= CRC_INIT;                         // Seed until the SFD
        end else if ((state_q == RX_DATA) && gmii_rx_dv) begin
            crc_q    <= crc32_byte(crc_q, gmii_rxd);
            dly_q[0] <= gmii_rxd;
            dly_q[1] <= dly_q[0];
            dly_q[2] <= dly_q[1];
            dly_q[3] <= dly_q[2];
            pend_q   <= dly_q[3];
        end
    end

endmodule

// ==== verilog/ethernet_mac_fifo.sv ====
module ethernet_mac_fifo #(
    parameter int FIFO_DEPTH = 2048,                   // Beats per FIFO
    parameter int FRAME_CNT_W = 9                      // Frame counter width in each FIFO
) (
    input  logic       clk_125,
    input  logic       i_reset_n,

    input  logic [7:0] tx_tdata,                       // User transmit stream
    input  logic       tx_tvalid,
    input  logic       tx_tlast,
    output logic       tx_tready,

    output logic [7:0] rx_tdata,                       // User receive stream
    output logic       rx_tvalid,
    output logic       rx_tlast,
    output logic       rx_tuser,                       // Bad frame, on the last beat
    input  logic       rx_tready,

    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv
);

    eth_stream_if tx_user ();                          // User to TX FIFO
    eth_stream_if tx_q ();                             // TX FIFO to TX MAC
    eth_stream_if rx_q ();                             // RX MAC to RX FIFO
    eth_stream_if rx_user ();                          // RX FIFO to user

    assign tx_user.beat  = '{data: tx_tdata, last: tx_tlast, err: 1'b0};
    assign tx_user.valid = tx_tvalid;
    assign tx_tready     = tx_user.ready;              // Low only while the TX FIFO is full

    assign rx_tdata      = rx_user.beat.data;
    assign rx_tlast      = rx_user.beat.last;
    assign rx_tuser      = rx_user.beat.err;
    assign rx_tvalid     = rx_user.valid;
    assign rx_user.ready = rx_tready;

    pkt_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .FRAME_CNT_W (FRAME_CNT_W)
    ) tx_fifo (
        .clk_125   (clk_125),
        .i_reset_n (i_reset_n),
        .wr        (tx_user),
        .rd        (tx_q)
    );

    eth_tx_mac u_tx_mac (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .s          (tx_q),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    eth_rx_mac u_rx_mac (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .m          (rx_q)
    );

    pkt_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .FRAME_CNT_W (FRAME_CNT_W)
    ) rx_fifo (
        .clk_125   (clk_125),
        .i_reset_n (i_reset_n),
        .wr        (rx_q),
        .rd        (rx_user)
    );

endmodule

// ==== tb/mac_checker.sv ====
module mac_checker import eth_frame_pkg::*; #(
    parameter int MAX_TESTS = 16,
    parameter int CORRUPT_POS = 19                     // Wire byte flipped by the loopback
) (
    input  logic         clk_125,
    input  logic         i_reset_n,
    input  logic         tx_tready,
    input  logic [7:0]   rx_tdata,
    input  logic         rx_tvalid,
    input  logic         rx_tlast,
    input  logic         rx_tuser,
    input  logic         rx_tready,
    input  logic [7:0]   gmii_txd,
    input  logic         gmii_tx_en,
    input  int           n_tests,
    input  logic [127:0] names [MAX_TESTS],
    input  int           lens [MAX_TESTS],
    input  logic [7:0]   starts [MAX_TESTS],
    input  logic [7:0]   steps [MAX_TESTS],
    input  logic         corrupts [MAX_TESTS],
    output int           n_done,                       // Frames fully received
    output int           n_fail,
    output int           n_other                       // Failures tied to no single test
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] exp_q [$];                             // Expected wire bytes of the current frame
    logic       tx_bad [MAX_TESTS] = '{default: 1'b0}; // Transmit side of a test went wrong
    logic       en_q = 1'b0;
    logic       rst_seen = 1'b0;
    logic       rx_bad = 1'b0;
    int         tx_idx;                                // Test whose frame is on the wire
    int         tx_pos;
    int         gap;                                   // Idle cycles since the last frame
    int         rx_idx;
    int         rx_pos;
    int         rst_bad;
    int         tx_stray;
    int         rx_stray;

    assign n_other = rst_bad + tx_stray + rx_stray;

    // Reflected IEEE CRC-32 worked one input bit at a time
    function automatic logic [31:0] crc_ref(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            c = (c[0] ^ d[b]) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    function automatic logic [7:0] pay_byte(input int t, input int i);
        return 8'(int'(starts[t]) + i * int'(steps[t])); // Start plus i times step modulo 256
    endfunction

    task automatic load_tx_frame(input int t);
        logic [31:0] crc;
        crc = CRC_INIT;
        exp_q.delete();
        for (int i = 0; i < PREAMBLE_LEN; i++) begin
            exp_q.push_back(PREAMBLE_BYTE);
        end
        exp_q.push_back(SFD_BYTE);
        for (int i = 0; i < lens[t]; i++) begin
            exp_q.push_back(pay_byte(t, i));
            crc = crc_ref(crc, pay_byte(t, i));
        end
        crc = ~crc;                                    // FCS is the complement
        for (int i = 0; i < FCS_LEN; i++) begin
            exp_q.push_back(crc[8*i +: 8]);            // Low byte first
        end
    endtask

    always @(posedge clk_125) begin
        if (i_reset_n && !rst_seen) begin              // First edge out of reset
            rst_seen <= 1'b1;
            if (gmii_tx_en !== 1'b0 || rx_tvalid !== 1'b0 || rx_tuser !== 1'b0
                    || tx_tready !== 1'b1) begin
                $display("ERR reset {tx_en,rx_tvalid,rx_tuser,tx_tready} expected 0001 actual %b%b%b%b",
                         gmii_tx_en, rx_tvalid, rx_tuser, tx_tready);
                rst_bad = 1;
            end else begin
                $display("PASS reset");
            end
        end
    end

    always @(posedge clk_125) begin
        if (i_reset_n) begin
            if (gmii_tx_en && !en_q) begin             // Frame starts on the wire
                if (tx_idx > 0 && tx_idx < n_tests && gap < IFG_LEN) begin
                    $display("ERR %0s gap expected >= %0d actual %0d",
                             names[tx_idx], IFG_LEN, gap);
                    tx_bad[tx_idx] = 1'b1;
                end
                if (tx_idx < n_tests) begin
                    load_tx_frame(tx_idx);
                end else begin
                    if (tx_stray == 0) $display("A transmit frame appeared after the last test");
                    tx_stray++;
                end
                tx_pos = 0;
            end
            if (gmii_tx_en) begin
                if (tx_idx < n_tests && tx_pos < exp_q.size()
                        && gmii_txd !== exp_q[tx_pos]) begin
                    $display("ERR %0s tx byte %0d expected %02h actual %02h",
                             names[tx_idx], tx_pos, exp_q[tx_pos], gmii_txd);
                    tx_bad[tx_idx] = 1'b1;
                end
                tx_pos++;
                gap = 0;
            end else begin
                if (en_q && tx_idx < n_tests && tx_pos != exp_q.size()) begin
                    $display("ERR %0s tx_en cycles expected %0d actual %0d",
                             names[tx_idx], exp_q.size(), tx_pos);
                    tx_bad[tx_idx] = 1'b1;
                end
                if (en_q) tx_idx++;                    // Frame ended last cycle
                gap++;
            end
            en_q = gmii_tx_en;
        end
    end

    always @(posedge clk_125) begin
        logic [7:0] want;
        logic       last_exp;
        logic       user_exp;
        logic       bad;
        if (i_reset_n && rx_tvalid && rx_tready) begin
            if (rx_idx >= n_tests) begin
                if (rx_stray == 0) $display("A receive beat appeared after the last test");
                rx_stray++;
            end else begin
                want     = pay_byte(rx_idx, rx_pos);
                last_exp = (rx_pos == lens[rx_idx] - 1);
                user_exp = last_exp && corrupts[rx_idx]; // Error flag only on the last beat
                if (corrupts[rx_idx] && rx_pos == CORRUPT_POS - PREAMBLE_LEN - 1) begin
                    want = want ^ 8'h01;               // Flipped on the way round
                end
                if (rx_tdata !== want) begin
                    $display("ERR %0s rx byte %0d expected %02h actual %02h",
                             names[rx_idx], rx_pos, want, rx_tdata);
                    rx_bad = 1'b1;
                end
                if (rx_tlast !== last_exp) begin
                    $display("ERR %0s rx_tlast at beat %0d expected %0b actual %0b",
                             names[rx_idx], rx_pos, last_exp, rx_tlast);
                    rx_bad = 1'b1;
                end
                if (rx_tuser !== user_exp) begin
                    $display("ERR %0s rx_tuser at beat %0d expected %0b actual %0b",
                             names[rx_idx], rx_pos, user_exp, rx_tuser);
                    rx_bad = 1'b1;
                end
                rx_pos++;
                if (rx_tlast) begin                    // Test complete
                    bad = rx_bad || tx_bad[rx_idx];
                    $display("%0s %0s, %0d bytes", bad ? "FAIL" : "PASS",
                             names[rx_idx], lens[rx_idx]);
                    n_fail += bad ? 1 : 0;
                    n_done++;
                    rx_idx++;
                    rx_pos = 0;
                    rx_bad = 1'b0;
                end
            end
        end
    end

endmodule

// ==== tb/tb_ethernet_mac_fifo.sv ====
module tb_ethernet_mac_fifo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS = 16;
    localparam int CORRUPT_POS = 19;                   // 20th byte on the wire, counted from 0
    localparam int RESET_CYCLES = 4;

    logic         clk_125;
    logic         i_reset_n;
    logic [7:0]   tx_tdata;
    logic         tx_tvalid;
    logic         tx_tlast;
    logic         tx_tready;
    logic [7:0]   rx_tdata;
    logic         rx_tvalid;
    logic         rx_tlast;
    logic         rx_tuser;
    logic         rx_tready;
    logic [7:0]   gmii_txd;
    logic         gmii_tx_en;
    logic [7:0]   gmii_rxd;
    logic         gmii_rx_dv;

    logic [127:0] names [MAX_TESTS];                   // Test table from the pattern file
    int           lens [MAX_TESTS];
    logic [7:0]   starts [MAX_TESTS];
    logic [7:0]   steps [MAX_TESTS];
    logic         corrupts [MAX_TESTS];
    logic         modes [MAX_TESTS];                   // 1 gives random rx_tready
    int           n_tests;
    int           limit;                               // Watchdog budget in cycles
    logic         loaded = 1'b0;
    int           n_done;
    int           n_fail;
    int           n_other;

    ethernet_mac_fifo #(.FIFO_DEPTH(2048), .FRAME_CNT_W(9)) dut (.*);

    mac_checker #(.MAX_TESTS(MAX_TESTS), .CORRUPT_POS(CORRUPT_POS)) chk (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic read_patterns(output logic ok);
        int           fd;
        int           got;
        string        line;
        logic [127:0] nm;
        int           len;
        int           cor;
        int           mode;
        logic [7:0]   st;
        logic [7:0]   sp;
        n_tests = 0;
        fd = $fopen("tb/frame_patterns.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin // Skip comments
                got = $sscanf(line, "%s %d %h %h %d %d", nm, len, st, sp, cor, mode);
                if (got == 6 && n_tests < MAX_TESTS) begin
                    names[n_tests]    = nm;
                    lens[n_tests]     = len;
                    starts[n_tests]   = st;
                    steps[n_tests]    = sp;
                    corrupts[n_tests] = (cor != 0);
                    modes[n_tests]    = (mode != 0);
                    n_tests++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        ok = (n_tests > 0);
    endtask

    task automatic send_frame(input int t);
        int i;
        i = 0;
        while (i < lens[t]) begin
            tx_tdata  = 8'(int'(starts[t]) + i * int'(steps[t]));
            tx_tvalid = 1'b1;
            tx_tlast  = (i == lens[t] - 1);
            @(posedge clk_125);
            if (tx_tready) i++;                        // Beat taken on this edge
            #10;
        end
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
    endtask

    initial begin
        clk_125 = 1'b0;
        forever #50 clk_125 = ~clk_125;                // 100 ns period
    end

    // GMII loopback, one cycle late, with a flipped bit for corrupt tests
    initial begin : loopback
        logic [7:0] d;
        logic       dv;
        int         pos;
        int         ti;
        pos = 0;
        ti = 0;
        gmii_rxd = 8'h00;
        gmii_rx_dv = 1'b0;
        forever begin
            @(posedge clk_125);
            d  = gmii_txd;
            dv = gmii_tx_en;
            if (dv && pos == CORRUPT_POS && ti < n_tests && corrupts[ti]) d = d ^ 8'h01;
            if (dv) begin
                pos++;
            end else if (pos != 0) begin               // Frame just ended
                pos = 0;
                ti++;
            end
            #10;
            gmii_rxd   = d;
            gmii_rx_dv = dv;
        end
    end

    initial begin : rx_ready_drive
        logic [31:0] rng;
        rng = 32'hb597a1b2;
        rx_tready = 1'b1;
        forever begin
            @(posedge clk_125);
            #10;
            rng = xorshift32(rng);
            rx_tready = (n_done < n_tests && modes[n_done]) ? rng[0] : 1'b1;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (limit) @(posedge clk_125);
        $display("Timeout after %0d cycles, %0d of %0d tests finished", limit, n_done, n_tests);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic ok;
        tx_tdata  = 8'h00;
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
        i_reset_n = 1'b0;
        read_patterns(ok);
        if (!ok) begin
            $display("No test could be read from tb/frame_patterns.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            limit = 1000;
            for (int t = 0; t < n_tests; t++) limit += (lens[t] + 30) * 4;
            loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk_125);
            #10;
            i_reset_n = 1'b1;
            for (int t = 0; t < n_tests; t++) send_frame(t); // No gaps between frames
            wait (n_done == n_tests);
            repeat (40) @(posedge clk_125);             // Room for stray frames or beats
            $display("Tests run %0d, passed %0d, failed %0d, other failures %0d",
                     n_done, n_done - n_fail, n_fail, n_other);
            if (n_fail == 0 && n_other == 0 && n_done == n_tests) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== tb/frame_patterns.txt ====
# name  length  start(hex)  step(hex)  corrupt  ready_mode
# payload byte i = start + i*step mod 256; ready_mode 1 drives rx_tready at random
single_byte 1 a5 00 0 0
ramp_64 64 00 01 0 0
min_frame_60 60 10 03 0 0
odd_len_97 97 ff 07 0 0
long_300 300 3c 0d 0 0
fcs_err_payload 40 20 01 1 0
fcs_err_in_fcs 10 80 11 1 0
b2b_rand_a 50 00 05 0 1
b2b_rand_b 128 7f 02 0 1
b2b_rand_c 33 e0 fd 0 1
b2b_rand_err 25 44 09 1 1
b2b_rand_d 200 01 01 0 1

// ==== verilog.f ====
verilog/eth_frame_pkg.sv
verilog/eth_stream_pkg.sv
verilog/eth_stream_if.sv
verilog/pkt_fifo.sv
verilog/eth_tx_mac.sv
verilog/eth_rx_mac.sv
verilog/ethernet_mac_fifo.sv
tb/mac_checker.sv
tb/tb_ethernet_mac_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_ethernet_mac_fifo \
    -Mdir obj_dir -o sim_tb -f verilog.f \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
